// ==== design/cache_pkg.sv ====
package cache_pkg;

    // ******************************************************************
    // Basic types and cache geometry
    // ******************************************************************

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strobe_t;

    // Port 0 is instruction fetch, port 1 is data
    localparam int NUM_PORTS = 2;
    localparam int PORT_BITS = $clog2(NUM_PORTS);

    localparam int LINE_WORDS  = 4;
    localparam int WORD_BITS   = $clog2(LINE_WORDS);
    localparam int INDEX_BITS  = 4;
    localparam int NUM_LINES   = 1 << INDEX_BITS;
    localparam int OFFSET_BITS = 4;
    localparam int WORD_LSB    = OFFSET_BITS - WORD_BITS;
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

    // Top three address bits of the unmapped kernel segments
    localparam logic [2:0] KSEG0_SEG = 3'b100;
    localparam logic [2:0] KSEG1_SEG = 3'b101;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [WORD_BITS-1:0]  word_sel_t;

    // ******************************************************************
    // Bus structs
    // ******************************************************************

    typedef struct packed {
        logic    valid;
        logic    is_write;
        strobe_t strobe;
        addr_t   addr;
        word_t   data;
    } cpu_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t data;
    } cpu_resp_t;

    typedef struct packed {
        logic    valid;
        logic    is_write;
        strobe_t strobe;
        addr_t   addr;
        word_t   data;
        logic    uncached;
    } phys_req_t;

    // len is the number of beats minus one
    typedef struct packed {
        logic       valid;
        logic       is_write;
        strobe_t    strobe;
        addr_t      addr;
        logic [1:0] len;
        word_t      data;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef enum logic [1:0] {
        C_IDLE,
        C_REFILL,
        C_UNCACHED_READ,
        C_WRITE
    } cache_state_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

// ==== design/mem_map.sv ====
`timescale 1ns/1ps

module mem_map import cache_pkg::*; (
    input  cpu_req_t  creq_in [NUM_PORTS],
    output phys_req_t preq    [NUM_PORTS]
);

    // ******************************************************************
    // Fixed segment translation, one copy per port
    // ******************************************************************

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_map
        logic [2:0] seg;
        logic       in_kseg0;
        logic       in_kseg1;

        assign seg      = creq_in[i].addr[31:29];
        assign in_kseg0 = (seg == KSEG0_SEG);
        assign in_kseg1 = (seg == KSEG1_SEG);

        always_comb begin
            preq[i].valid    = creq_in[i].valid;
            preq[i].is_write = creq_in[i].is_write;
            preq[i].strobe   = creq_in[i].strobe;
            preq[i].data     = creq_in[i].data;
            preq[i].addr     = creq_in[i].addr;

            // kseg0 and kseg1 both alias the low 512 MB of physical space
            if (in_kseg0 || in_kseg1) begin
                preq[i].addr[31:29] = 3'b000;
            end

            // Only kseg1 bypasses the cache
            preq[i].uncached = in_kseg1;
        end
    end

endmodule

// ==== design/port_cache.sv ====
`timescale 1ns/1ps

module port_cache import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  phys_req_t  preq,
    output cpu_resp_t  cresp,
    output cbus_req_t  mreq,
    input  cbus_resp_t mresp
);

    cache_state_t state;

    // ******************************************************************
    // Storage
    // ******************************************************************

    word_t                data_mem [NUM_LINES][LINE_WORDS];
    tag_t                 tag_mem  [NUM_LINES];
    logic [NUM_LINES-1:0] line_valid;

    // Request captured when it is accepted
    phys_req_t cur;
    word_t     rdata_q;
    logic      data_ok_q;
    word_sel_t beat_cnt;

    index_t    req_index;
    word_sel_t req_word;
    tag_t      req_tag;
    logic      hit;
    logic      accept;
    logic      beat_done;

    index_t    cur_index;
    word_sel_t cur_word;
    tag_t      cur_tag;

    function automatic word_t merge_bytes(
        input word_t   old_word,
        input word_t   new_word,
        input strobe_t strobe
    );
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign req_index = preq.addr[OFFSET_BITS +: INDEX_BITS];
    assign req_word  = preq.addr[WORD_LSB +: WORD_BITS];
    assign req_tag   = preq.addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];

    assign cur_index = cur.addr[OFFSET_BITS +: INDEX_BITS];
    assign cur_word  = cur.addr[WORD_LSB +: WORD_BITS];
    assign cur_tag   = cur.addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];

    assign hit = line_valid[req_index] && (tag_mem[req_index] == req_tag);

    // The master still holds its request during the data_ok cycle
    assign accept    = (state == C_IDLE) && preq.valid && !data_ok_q;
    assign beat_done = mresp.ready && mresp.last;

    // ******************************************************************
    // Control FSM
    // ******************************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= C_IDLE;
            line_valid <= '0;
            beat_cnt   <= '0;
            data_ok_q  <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (accept) begin
                        if (preq.is_write) begin
                            state <= C_WRITE;
                        end else if (preq.uncached) begin
                            state <= C_UNCACHED_READ;
                        end else if (hit) begin
                            data_ok_q <= 1'b1;
                        end else begin
                            state    <= C_REFILL;
                            beat_cnt <= '0;
                        end
                    end
                end
                C_REFILL: begin
                    if (mresp.ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (mresp.last) begin
                            line_valid[cur_index] <= 1'b1;
                            state                 <= C_IDLE;
                            data_ok_q             <= 1'b1;
                        end
                    end
                end
                C_UNCACHED_READ, C_WRITE: begin
                    if (beat_done) begin
                        state     <= C_IDLE;
                        data_ok_q <= 1'b1;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // Data path registers and line storage
    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= preq;
            if (!preq.is_write && !preq.uncached && hit) begin
                rdata_q <= data_mem[req_index][req_word];
            end
            // Write hit updates the line, a write miss leaves the cache alone
            if (preq.is_write && hit) begin
                data_mem[req_index][req_word] <= merge_bytes(
                    data_mem[req_index][req_word], preq.data, preq.strobe);
            end
        end
        if (state == C_REFILL && mresp.ready) begin
            data_mem[cur_index][beat_cnt] <= mresp.data;
            if (beat_cnt == cur_word) begin
                rdata_q <= mresp.data;
            end
            if (mresp.last) begin
                tag_mem[cur_index] <= cur_tag;
            end
        end
        if (state == C_UNCACHED_READ && beat_done) begin
            rdata_q <= mresp.data;
        end
    end

    // ******************************************************************
    // Bus request and port response
    // ******************************************************************

    always_comb begin
        mreq.valid    = (state != C_IDLE);
        mreq.is_write = (state == C_WRITE);
        mreq.strobe   = (state == C_WRITE) ? cur.strobe : '0;
        mreq.addr     = cur.addr;
        mreq.len      = 2'd0;
        mreq.data     = cur.data;
        if (state == C_REFILL) begin
            mreq.addr = {cur.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            mreq.len  = 2'(LINE_WORDS - 1);
        end
    end

    assign cresp.data_ok = data_ok_q;
    assign cresp.data    = rdata_q;

    // A pending bus request must not move until its last beat
    assert property (@(posedge clk) disable iff (!arst_n)
        (mreq.valid && !beat_done) |=> (mreq.valid && $stable(mreq)))
        else $error("port_cache: bus request changed before last beat");

    assert property (@(posedge clk) disable iff (!arst_n)
        cresp.data_ok |=> !cresp.data_ok)
        else $error("port_cache: data_ok held for two cycles");

endmodule

// ==== design/cbus_arbiter.sv ====
`timescale 1ns/1ps

module cbus_arbiter import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  cbus_req_t  mreq  [NUM_PORTS],
    output cbus_resp_t mresp [NUM_PORTS],
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    arb_state_t           state;
    logic [PORT_BITS-1:0] grant_q;
    logic [PORT_BITS-1:0] ptr;
    logic [PORT_BITS-1:0] pick;
    logic [PORT_BITS-1:0] sel;
    logic                 burst_end;

    function automatic logic [PORT_BITS-1:0] next_port(input logic [PORT_BITS-1:0] port);
        if (int'(port) == NUM_PORTS - 1) begin
            return '0;
        end
        return port + 1'b1;
    endfunction

    // ******************************************************************
    // Round-robin pick, starting at the priority pointer
    // ******************************************************************

    always_comb begin
        int   idx;
        logic found;
        pick  = ptr;
        found = 1'b0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = (int'(ptr) + k) % NUM_PORTS;
            if (!found && mreq[idx].valid) begin
                pick  = PORT_BITS'(idx);
                found = 1'b1;
            end
        end
    end

    // Forwarding is combinational so the arbiter adds no cycle
    assign sel       = (state == ARB_BUSY) ? grant_q : pick;
    assign burst_end = cbus_req.valid && cbus_resp.ready && cbus_resp.last;

    always_comb begin
        cbus_req = mreq[sel];
        for (int i = 0; i < NUM_PORTS; i++) begin
            mresp[i]       = cbus_resp;
            mresp[i].ready = cbus_resp.ready && cbus_req.valid && (sel == PORT_BITS'(i));
            mresp[i].last  = cbus_resp.last && cbus_req.valid && (sel == PORT_BITS'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ARB_IDLE;
            grant_q <= '0;
            ptr     <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (cbus_req.valid) begin
                        // A zero-wait single beat finishes without locking
                        if (burst_end) begin
                            ptr <= next_port(sel);
                        end else begin
                            state   <= ARB_BUSY;
                            grant_q <= sel;
                        end
                    end
                end
                ARB_BUSY: begin
                    if (burst_end) begin
                        state <= ARB_IDLE;
                        ptr   <= next_port(grant_q);
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // The locked master has to keep asking until its last beat
    assert property (@(posedge clk) disable iff (!arst_n)
        (state == ARB_BUSY) |-> mreq[grant_q].valid)
        else $error("cbus_arbiter: granted master dropped valid before last");

endmodule

// ==== design/cache_manage.sv ====
`timescale 1ns/1ps

module cache_manage import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,

    input  cpu_req_t   creq_in   [NUM_PORTS],
    output cpu_resp_t  cresp_out [NUM_PORTS],

    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    phys_req_t  preq       [NUM_PORTS];
    cbus_req_t  port_mreq  [NUM_PORTS];
    cbus_resp_t port_mresp [NUM_PORTS];

    // ******************************************************************
    // Address translation for all ports
    // ******************************************************************

    mem_map mmu (
        .creq_in (creq_in),
        .preq    (preq)
    );

    // Fetch and data each get an identical cache and the fetch master never writes
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        port_cache cache (
            .clk   (clk),
            .arst_n(arst_n),
            .preq  (preq[i]),
            .cresp (cresp_out[i]),
            .mreq  (port_mreq[i]),
            .mresp (port_mresp[i])
        );
    end

    // ******************************************************************
    // Memory bus
    // ******************************************************************

    cbus_arbiter arbiter (
        .clk      (clk),
        .arst_n   (arst_n),
        .mreq     (port_mreq),
        .mresp    (port_mresp),
        .cbus_req (cbus_req),
        .cbus_resp(cbus_resp)
    );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset is let go just after a rising edge, well away from the next one
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

// ==== test/cache_manage_checker.sv ====
`timescale 1ns/1ps

module cache_manage_checker import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  cpu_req_t   creq_in    [NUM_PORTS],
    input  cpu_resp_t  cresp_out  [NUM_PORTS],
    input  logic       expect_hit [NUM_PORTS],
    input  cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp,
    output int         data_errors,
    output int         protocol_errors
);

    localparam int MEM_WORDS = 4096;

    word_t     shadow  [MEM_WORDS];
    logic      pending [NUM_PORTS];
    int        latency [NUM_PORTS];
    logic      seen_req;
    logic      bus_hold;
    cbus_req_t bus_prev;

    function automatic word_t fill_word(input addr_t paddr);
        return (paddr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    // kseg0 and kseg1 lose their top three bits and everything else is physical already
    function automatic addr_t map_addr(input addr_t vaddr);
        if (vaddr[31:29] == 3'b100 || vaddr[31:29] == 3'b101) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

    function automatic word_t expected_read(input addr_t vaddr);
        addr_t paddr;
        paddr = map_addr(vaddr);
        return shadow[paddr[13:2]];
    endfunction

    // Cached reads refill a whole line while writes and uncached reads move one word
    function automatic logic bus_req_matches(input cbus_req_t req);
        addr_t paddr;
        logic  refill;
        for (int p = 0; p < NUM_PORTS; p++) begin
            paddr  = map_addr(creq_in[p].addr);
            refill = !creq_in[p].is_write && creq_in[p].addr[31:29] != 3'b101;
            if (refill) begin
                paddr[OFFSET_BITS-1:0] = '0;
            end
            if (creq_in[p].valid && req.addr == paddr
                && req.is_write == creq_in[p].is_write
                && int'(req.len) == (refill ? LINE_WORDS - 1 : 0)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic apply_write(input addr_t vaddr, input word_t data, input strobe_t strobe);
        addr_t paddr;
        paddr = map_addr(vaddr);
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                shadow[paddr[13:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    initial begin
        data_errors     = 0;
        protocol_errors = 0;
        seen_req        = 1'b0;
        bus_hold        = 1'b0;
        bus_prev        = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            pending[p] = 1'b0;
            latency[p] = 0;
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            shadow[w] = fill_word(addr_t'(w * 4));
        end
    end

    // ******************************************************************
    // Bus and port monitoring on the rising edge
    // ******************************************************************

    always @(posedge clk) begin
        word_t expected;
        if (arst_n) begin
            if (cbus_req.valid && !seen_req) begin
                protocol_errors++;
                $display("%0t: bus valid went high before any port request", $time);
            end
            if (cbus_req.valid && !bus_req_matches(cbus_req)) begin
                protocol_errors++;
                $display("%0t: bus request for %h matches no held port request", $time,
                         cbus_req.addr);
            end
            if (bus_hold && cbus_req != bus_prev) begin
                protocol_errors++;
                $display("%0t: bus request changed while it was pending", $time);
            end
            bus_hold = cbus_req.valid && !(cbus_resp.ready && cbus_resp.last);
            bus_prev = cbus_req;

            for (int p = 0; p < NUM_PORTS; p++) begin
                if (creq_in[p].valid) begin
                    seen_req = 1'b1;
                end
                if (cresp_out[p].data_ok) begin
                    if (!pending[p]) begin
                        protocol_errors++;
                        $display("%0t: port %0d raised data_ok with no pending request",
                                 $time, p);
                    end else if (creq_in[p].is_write) begin
                        apply_write(creq_in[p].addr, creq_in[p].data, creq_in[p].strobe);
                    end else begin
                        expected = expected_read(creq_in[p].addr);
                        if (cresp_out[p].data !== expected) begin
                            data_errors++;
                            $display("FAIL %0t: cresp_out[%0d].data got %h expected %h",
                                     $time, p, cresp_out[p].data, expected);
                        end
                    end
                    if (pending[p] && expect_hit[p] && latency[p] != 1) begin
                        protocol_errors++;
                        $display("FAIL %0t: cresp_out[%0d].data_ok latency got %0d expected 1",
                                 $time, p, latency[p]);
                    end
                    pending[p] = 1'b0;
                end else if (creq_in[p].valid && !pending[p]) begin
                    pending[p] = 1'b1;
                    latency[p] = 1;
                end else if (pending[p]) begin
                    latency[p]++;
                end
            end
        end
    end

endmodule

// ==== test/cache_manage_tb.sv ====
`timescale 1ns/1ps

module cache_manage_tb import cache_pkg::*; ();

    localparam int MEM_WORDS  = 4096;
    localparam int CLK_PERIOD = 8;
    localparam int SEED       = 48183;

    // Requests issued by each phase over both ports
    localparam int P1_REQS      = 16;
    localparam int P2_REQS      = 10;
    localparam int P3_REQS      = 5;
    localparam int P4_REQS      = 16;
    localparam int P5_REQS      = 8;
    localparam int NUM_REQUESTS = P1_REQS + P2_REQS + P3_REQS + P4_REQS + P5_REQS;

    logic       clk;
    logic       arst_n;
    cpu_req_t   creq_in    [NUM_PORTS];
    cpu_resp_t  cresp_out  [NUM_PORTS];
    logic       expect_hit [NUM_PORTS];
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;
    int         data_errors;
    int         protocol_errors;
    word_t      mem [MEM_WORDS];

    tb_clock clock_gen (
        .clk   (clk),
        .arst_n(arst_n)
    );

    cache_manage dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .creq_in  (creq_in),
        .cresp_out(cresp_out),
        .cbus_req (cbus_req),
        .cbus_resp(cbus_resp)
    );

    cache_manage_checker check (
        .clk            (clk),
        .arst_n         (arst_n),
        .creq_in        (creq_in),
        .cresp_out      (cresp_out),
        .expect_hit     (expect_hit),
        .cbus_req       (cbus_req),
        .cbus_resp      (cbus_resp),
        .data_errors    (data_errors),
        .protocol_errors(protocol_errors)
    );

    function automatic word_t fill_word(input addr_t paddr);
        return (paddr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // ******************************************************************
    // Memory bus responder
    // ******************************************************************

    task automatic serve_burst();
        cbus_req_t req;
        int        idx;
        req = cbus_req;
        for (int beat = 0; beat <= int'(req.len); beat++) begin
            repeat ($urandom % 4) next_cycle();
            idx = int'(req.addr[13:2]) + beat;
            if (req.is_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.strobe[b]) begin
                        mem[idx][8*b +: 8] = req.data[8*b +: 8];
                    end
                end
            end
            cbus_resp.ready = 1'b1;
            cbus_resp.last  = (beat == int'(req.len));
            cbus_resp.data  = req.is_write ? '0 : mem[idx];
            next_cycle();
            cbus_resp = '0;
        end
    endtask

    task automatic respond_to_bus();
        cbus_resp = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem[w] = fill_word(addr_t'(w * 4));
        end
        wait (arst_n === 1'b1);
        next_cycle();
        forever begin
            if (cbus_req.valid) begin
                serve_burst();
            end else begin
                next_cycle();
            end
        end
    endtask

    // ******************************************************************
    // Port stimulus
    // ******************************************************************

    // Holds the request through the data_ok cycle and lets it go one cycle later
    task automatic port_access(input int port, input logic wr, input strobe_t strobe,
                               input addr_t addr, input logic hit);
        creq_in[port].valid    = 1'b1;
        creq_in[port].is_write = wr;
        creq_in[port].strobe   = strobe;
        creq_in[port].addr     = addr;
        creq_in[port].data     = $urandom;
        expect_hit[port]       = hit;
        do begin
            next_cycle();
        end while (!cresp_out[port].data_ok);
        next_cycle();
        creq_in[port].valid = 1'b0;
    endtask

    task automatic read_word(input int port, input addr_t addr, input logic hit);
        port_access(port, 1'b0, 4'b0000, addr, hit);
    endtask

    task automatic write_word(input addr_t addr, input strobe_t strobe);
        port_access(1, 1'b1, strobe, addr, 1'b0);
    endtask

    task automatic fetch_repeat_reads();
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 8; i++) begin
                read_word(0, 32'h8000_0000 + 4 * i, pass == 1);
            end
        end
    endtask

    // Even words are loaded first so the store hits and odd words take a write miss
    task automatic store_merge_phase();
        addr_t addr;
        for (int i = 0; i < 4; i++) begin
            addr = 32'h8000_1000 + 32 * i;
            if (i % 2 == 0) begin
                read_word(1, addr, 1'b0);
            end
            write_word(addr, strobe_t'(4'b0011 << i));
            read_word(1, addr, i % 2 == 0);
        end
    endtask

    // 0x2000_1200 lies outside kseg0 and kseg1 and reaches the bus untranslated
    // The memory model decodes only the low 14 bits so 0xa000_1200 sees the same word
    task automatic kseg1_phase();
        write_word(32'h8000_1100, 4'b1111);
        read_word(1, 32'ha000_1100, 1'b0);
        write_word(32'h2000_1200, 4'b0110);
        read_word(1, 32'h2000_1200, 1'b0);
        read_word(1, 32'ha000_1200, 1'b0);
    endtask

    task automatic miss_stream(input int port, input addr_t base);
        for (int i = 0; i < 8; i++) begin
            read_word(port, base + 16 * i, 1'b0);
        end
    endtask

    // Both addresses share index 4, so every switch evicts the other line
    task automatic replacement_phase();
        for (int i = 0; i < 6; i++) begin
            read_word(1, (i % 2 == 0) ? 32'h8000_3040 : 32'h8000_3144, 1'b0);
            if (i == 2 || i == 3) begin
                write_word(32'h8000_3144, 4'b1001);
            end
        end
    endtask

    initial begin : stimulus
        void'($urandom(SEED));
        for (int p = 0; p < NUM_PORTS; p++) begin
            creq_in[p]    = '0;
            expect_hit[p] = 1'b0;
        end
        fork
            respond_to_bus();
        join_none
        wait (arst_n === 1'b1);
        repeat (4) next_cycle();
        fork
            fetch_repeat_reads();
            store_merge_phase();
        join
        kseg1_phase();
        fork
            miss_stream(0, 32'h8000_0800);
            miss_stream(1, 32'h8000_2000);
        join
        replacement_phase();
        repeat (2) next_cycle();
        $display("checks done: %0d data errors, %0d protocol errors",
                 data_errors, protocol_errors);
        if (data_errors + protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_REQUESTS * 60 * CLK_PERIOD);
        $display("timeout: %0d requests did not finish in time", NUM_REQUESTS);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== build.f ====
design/cache_pkg.sv
design/mem_map.sv
design/port_cache.sv
design/cbus_arbiter.sv
design/cache_manage.sv
test/tb_clock.sv
test/cache_manage_checker.sv
test/cache_manage_tb.sv
